/* verilog.f */
rename_isa_pkg.sv
rename_core_pkg.sv
instr_decode.sv
free_list.sv
rename_table.sv
rename_unit.sv
rename_chk.sv
rename_tb.sv

/* rename_tb.sv */
// Only ALU, load, store and conditional branch opcodes are sent; JAL and JALR are not exercised
`timescale 1ns/1ns

module rename_tb
    import rename_isa_pkg::*, rename_core_pkg::*;
();

    logic         clk;
    logic         rstn;
    logic         req;
    instr_t       instr;
    wb_t          wb;
    commit_t      commit;
    branch_ctl_t  branch;
    logic         ack;
    logic         uop_valid;
    renamed_uop_t uop;
    logic         out_of_ckpt;

    // Reference model state
    phreg_t map [NUM_ISA_REGISTERS];
    logic   rdy [NUM_ISA_REGISTERS];
    phreg_t cmap [NUM_ISA_REGISTERS];
    phreg_t fl_q [$];                   // Every register ever freed, in order
    int     fl_head;
    int     commit_cnt;
    int     label;                      // Working map version
    phreg_t ck_map [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic   ck_rdy [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    int     ck_fl [NUM_CHECKPOINTS];
    int     ck_seq [NUM_CHECKPOINTS];
    int     ck_live [$];                // Live labels, oldest first
    reg_t   fi_rd [$];                  // In-flight writers, oldest first
    phreg_t fi_pd [$];
    phreg_t fi_old [$];
    int     fi_seq [$];
    int     wr_seq;

    rename_unit UUT (
        .clk_i                (clk),
        .rstn_i               (rstn),
        .req_i                (req),
        .instr_i              (instr),
        .wb_i                 (wb),
        .commit_i             (commit),
        .branch_i             (branch),
        .ack_o                (ack),
        .uop_valid_o          (uop_valid),
        .uop_o                (uop),
        .out_of_checkpoints_o (out_of_ckpt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopping at first error");
    endtask

    always @(posedge clk) begin
        if (UUT.u_chk.fail_count != 0) begin
            abort_run("An assertion in the bound checker failed");
        end
    end

    task automatic check_uop(renamed_uop_t got, renamed_uop_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail %0t ns: %s uop got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail %0t ns: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic wait_ack(logic level, string what);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (ack !== level) begin
            if (cnt >= 50) begin
                abort_run($sformatf("Timeout waiting for ack_o to become %b during %s",
                                    level, what));
            end
            @(negedge clk);
            cnt++;
        end
    endtask

    // Side inputs are held for exactly one sampling edge
    task automatic apply_cycle(wb_t w, commit_t c, branch_ctl_t b);
        @(posedge clk);
        wb     <= w;
        commit <= c;
        branch <= b;
        @(posedge clk);
        wb     <= '0;
        commit <= '0;
        branch <= '0;
    endtask

    function automatic int free_count();
        return fl_q.size() - fl_head;
    endfunction

    function automatic instr_t make_instr(opcode_t op, reg_t rd);
        return {7'($urandom), reg_t'($urandom), reg_t'($urandom), 3'($urandom), rd, op};
    endfunction

    task automatic apply_wb(wb_t w);
        if (w.valid) begin
            if (map[w.vreg] == w.preg) rdy[w.vreg] = 1'b1;
            foreach (ck_live[i]) begin
                if (ck_map[ck_live[i]][w.vreg] == w.preg) ck_rdy[ck_live[i]][w.vreg] = 1'b1;
            end
        end
    endtask

    task automatic pick_wb(output wb_t w);
        int idx;
        w = '0;
        if (fi_rd.size() > 0) begin
            idx = $urandom_range(0, fi_rd.size() - 1);
            w = '{valid: 1'b1, vreg: fi_rd[idx], preg: fi_pd[idx]};
        end
    endtask

    // Expected uop from the decode and ready rules, then the model update
    task automatic predict(instr_t ins, wb_t w, output renamed_uop_t exp);
        opcode_t op;
        reg_t    rd;
        reg_t    rs1;
        reg_t    rs2;
        logic    use1;
        logic    use2;
        logic    wr;
        op   = ins[6:0];
        rd   = ins[11:7];
        rs1  = ins[19:15];
        rs2  = ins[24:20];
        use1 = op inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_STORE, OPCODE_BRANCH};
        use2 = op inside {OPCODE_OP, OPCODE_STORE, OPCODE_BRANCH};
        wr   = (op inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LOAD}) && (rd != '0);
        exp.prs1       = map[rs1];
        exp.prs2       = map[rs2];
        exp.old_pdst   = map[rd];
        exp.rdy1       = rdy[rs1] | (w.valid && w.vreg == rs1 && w.preg == map[rs1]) | !use1;
        exp.rdy2       = rdy[rs2] | (w.valid && w.vreg == rs2 && w.preg == map[rs2]) | !use2;
        exp.pdst       = wr ? fl_q[fl_head] : '0;
        exp.checkpoint = checkpoint_ptr'(label);
        apply_wb(w);
        if (op == OPCODE_BRANCH) begin
            ck_map[label] = map;
            ck_rdy[label] = rdy;
            ck_fl[label]  = fl_head;
            ck_seq[label] = wr_seq;
            ck_live.push_back(label);
            label = (label + 1) % NUM_CHECKPOINTS;
        end
        if (wr) begin
            fi_rd.push_back(rd);
            fi_pd.push_back(exp.pdst);
            fi_old.push_back(map[rd]);
            fi_seq.push_back(wr_seq);
            map[rd] = exp.pdst;
            rdy[rd] = 1'b0;
            fl_head++;
            wr_seq++;
        end
    endtask

    task automatic finish_rename(renamed_uop_t exp, string what);
        wait_ack(1'b1, what);
        check_flag(uop_valid, 1'b1, {what, " uop_valid_o"});
        check_uop(uop, exp, what);
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0, what);
    endtask

    task automatic rename_one(instr_t ins, wb_t w, string what);
        renamed_uop_t exp;
        predict(ins, w, exp);
        @(posedge clk);
        req   <= 1'b1;
        instr <= ins;
        wb    <= w;       // Lands on the fire edge for the bypass
        @(posedge clk);
        wb    <= '0;
        finish_rename(exp, what);
    endtask

    task automatic commit_oldest();
        commit_t c;
        if (fi_rd.size() > 0) begin
            c = '{valid: 1'b1, vreg: fi_rd[0], new_preg: fi_pd[0], old_preg: fi_old[0]};
            cmap[fi_rd[0]] = fi_pd[0];
            fl_q.push_back(fi_old[0]);
            commit_cnt++;
            void'(fi_rd.pop_front());
            void'(fi_pd.pop_front());
            void'(fi_old.pop_front());
            void'(fi_seq.pop_front());
            apply_cycle('0, c, '0);
        end
    endtask

    task automatic delete_oldest();
        void'(ck_live.pop_front());
        apply_cycle('0, '0, '{recover: 1'b0, recover_ckpt: '0, delete_ckpt: 1'b1,
                              exception: 1'b0});
    endtask

    task automatic recover_to(int l);
        map     = ck_map[l];
        rdy     = ck_rdy[l];
        fl_head = ck_fl[l];
        label   = l;
        while (fi_seq.size() > 0 && fi_seq[$] >= ck_seq[l]) begin
            void'(fi_rd.pop_back());
            void'(fi_pd.pop_back());
            void'(fi_old.pop_back());
            void'(fi_seq.pop_back());
        end
        while (ck_live.size() > 0 && ck_live[$] != l) void'(ck_live.pop_back());
        void'(ck_live.pop_back());   // The mispredicted branch itself
        apply_cycle('0, '0, '{recover: 1'b1, recover_ckpt: checkpoint_ptr'(l),
                              delete_ckpt: 1'b0, exception: 1'b0});
    endtask

    task automatic raise_exception();
        map     = cmap;
        fl_head = commit_cnt;
        label   = 0;
        foreach (rdy[r]) rdy[r] = 1'b1;
        fi_rd.delete();
        fi_pd.delete();
        fi_old.delete();
        fi_seq.delete();
        ck_live.delete();
        apply_cycle('0, '0, '{recover: 1'b0, recover_ckpt: '0, delete_ckpt: 1'b0,
                              exception: 1'b1});
    endtask

    // Request held while the DUT back-pressures, then one side action frees it
    task automatic blocked_rename(instr_t ins, logic use_delete, string what);
        renamed_uop_t exp;
        @(posedge clk);
        req   <= 1'b1;
        instr <= ins;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_flag(ack, 1'b0, {what, " ack_o while blocked"});
        end
        if (use_delete) delete_oldest();
        else commit_oldest();
        predict(ins, '0, exp);
        finish_rename(exp, what);
    endtask

    task automatic drain_commits(int want);
        while (free_count() < want && fi_rd.size() > 0) commit_oldest();
    endtask

    initial begin
        int     kind;
        int     lbl;
        instr_t ins;
        wb_t    w;
        void'($urandom(32'hbcf4_5af9));
        rstn   = 1'b0;
        req    = 1'b0;
        instr  = '0;
        wb     = '0;
        commit = '0;
        branch = '0;
        for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
            map[r]  = phreg_t'(r);
            cmap[r] = phreg_t'(r);
            rdy[r]  = 1'b1;
            fl_q.push_back(phreg_t'(NUM_ISA_REGISTERS + r));
        end
        fl_head    = 0;
        commit_cnt = 0;
        label      = 0;
        wr_seq     = 0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag(ack, 1'b0, "ack_o after reset");
        check_flag(uop_valid, 1'b0, "uop_valid_o after reset");
        check_flag(out_of_ckpt, 1'b0, "out_of_checkpoints_o after reset");

        // Random ALU, load, store and x0 traffic with writebacks and commits
        for (int n = 0; n < 40; n++) begin
            kind = $urandom_range(0, 4);
            case (kind)
                0: ins = make_instr(OPCODE_OP, reg_t'($urandom_range(1, 31)));
                1: ins = make_instr(OPCODE_OP_IMM, reg_t'($urandom_range(1, 31)));
                2: ins = make_instr(OPCODE_LOAD, reg_t'($urandom_range(1, 31)));
                3: ins = make_instr(OPCODE_STORE, reg_t'($urandom));
                default: ins = make_instr(OPCODE_OP, '0);
            endcase
            w = '0;
            if ($urandom_range(0, 1) == 1) pick_wb(w);
            rename_one(ins, w, "random rename");
            if ($urandom_range(0, 2) == 0) begin
                pick_wb(w);
                apply_wb(w);
                apply_cycle(w, '0, '0);
            end
            if (free_count() < 6 || $urandom_range(0, 2) == 0) commit_oldest();
        end

        // Branch, wrong path, recover
        drain_commits(24);
        lbl = label;
        rename_one(make_instr(OPCODE_BRANCH, reg_t'($urandom)), '0, "branch");
        for (int n = 0; n < 3; n++) begin
            pick_wb(w);
            rename_one(make_instr(OPCODE_OP, reg_t'($urandom_range(1, 31))), w, "wrong path");
        end
        recover_to(lbl);
        for (int n = 0; n < 3; n++) begin
            rename_one(make_instr(OPCODE_LOAD, reg_t'($urandom_range(1, 31))), '0, "after recover");
        end

        // Fill all checkpoints, then a branch waits for a delete
        for (int n = 0; n < 3; n++) begin
            rename_one(make_instr(OPCODE_BRANCH, reg_t'($urandom)), '0, "branch fill");
            rename_one(make_instr(OPCODE_OP, reg_t'($urandom_range(1, 31))), '0, "between branches");
        end
        check_flag(out_of_ckpt, ck_live.size() == NUM_CHECKPOINTS - 1, "out_of_checkpoints_o full");
        blocked_rename(make_instr(OPCODE_BRANCH, reg_t'($urandom)), 1'b1, "branch after delete");
        while (ck_live.size() > 0) delete_oldest();
        @(negedge clk);
        check_flag(out_of_ckpt, 1'b0, "out_of_checkpoints_o after deletes");

        // Commits then an exception
        drain_commits(24);
        for (int n = 0; n < 6; n++) begin
            rename_one(make_instr(OPCODE_OP, reg_t'($urandom_range(1, 31))), '0, "before exception");
            if ($urandom_range(0, 1) == 1) commit_oldest();
        end
        raise_exception();
        for (int n = 0; n < 4; n++) begin
            rename_one(make_instr(OPCODE_OP, reg_t'($urandom_range(1, 31))), '0, "after exception");
        end
        check_flag(out_of_ckpt, 1'b0, "out_of_checkpoints_o after exception");

        // Run the free list dry, then one commit unblocks a writer
        while (free_count() > 0) begin
            rename_one(make_instr(OPCODE_OP, reg_t'($urandom_range(1, 31))), '0, "fill free list");
        end
        blocked_rename(make_instr(OPCODE_OP, reg_t'($urandom_range(1, 31))), 1'b0,
                       "writer after commit");

        repeat (2) @(posedge clk);
        if (UUT.u_chk.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("An assertion in the bound checker failed");
        end
    end

endmodule

/* rename_chk.sv */
// Bound into rename_unit; reads its internal fire, decode and free-list nets by name
`timescale 1ns/1ns

module rename_chk
    import rename_isa_pkg::*, rename_core_pkg::*;
(
    input logic   clk_i,
    input logic   rstn_i,
    input logic   req_i,
    input logic   ack_i,
    input logic   uop_valid_i,
    input logic   fire_i,
    input logic   write_rd_i,
    input phreg_t free_preg_i
);

    int fail_count = 0;

    // Ack only answers a request that is or was just high
    ack_follows_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_i |-> (req_i || $past(req_i)))
        else begin
            $error("ack_o high without a preceding req_i");
            fail_count++;
        end

    uop_valid_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        uop_valid_i |=> !uop_valid_i)
        else begin
            $error("uop_valid_o longer than one cycle");
            fail_count++;
        end

    // p0 belongs to x0 for good
    pdst_not_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (fire_i && write_rd_i) |-> (free_preg_i != '0))
        else begin
            $error("Destination allocated as p0");
            fail_count++;
        end

endmodule

bind rename_unit rename_chk u_chk (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_i       (req_i),
    .ack_i       (ack_o),
    .uop_valid_i (uop_valid_o),
    .fire_i      (rename_fire),
    .write_rd_i  (dec.write_rd),
    .free_preg_i (free_preg)
);

/* rename_unit.sv */
// One instruction per four-phase req/ack; uop_o is valid only while uop_valid_o is high
`timescale 1ns/1ns

module rename_unit
    import rename_isa_pkg::*, rename_core_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         req_i,
    input  instr_t       instr_i,
    input  wb_t          wb_i,
    input  commit_t      commit_i,
    input  branch_ctl_t  branch_i,
    output logic         ack_o,
    output logic         uop_valid_o,
    output renamed_uop_t uop_o,
    output logic         out_of_checkpoints_o
);

    decoded_instr_t dec;
    phreg_t         free_preg;
    phreg_t         src1;
    phreg_t         src2;
    phreg_t         old_dst;
    phreg_t         pdst_q;
    logic           free_empty;
    logic           rdy1;
    logic           rdy2;
    logic           out_of_ckpt;
    checkpoint_ptr  ckpt_label;
    logic           rename_fire;
    logic           pop;
    logic           take_ckpt;
    logic           in_progress_q;   // Between fire and ack
    logic           ack_q;
    logic           uop_valid_q;
    renamed_uop_t   uop_q;

    instr_decode u_decode (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    // Fire once per request; back-pressure just holds off
    assign rename_fire = req_i && !ack_q && !in_progress_q
                         && !branch_i.recover && !branch_i.exception
                         && (!free_empty || !dec.write_rd)
                         && (!out_of_ckpt || !dec.is_branch);
    assign pop       = rename_fire && dec.write_rd;
    assign take_ckpt = rename_fire && dec.is_branch;

    free_list u_free_list (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .pop_i        (pop),
        .push_i       (commit_i),
        .checkpoint_i (take_ckpt),
        .branch_i     (branch_i),
        .free_preg_o  (free_preg),
        .empty_o      (free_empty)
    );

    rename_table u_table (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .dec_i                (dec),
        .rename_i             (rename_fire),
        .new_dst_i            (free_preg),
        .checkpoint_i         (take_ckpt),
        .wb_i                 (wb_i),
        .commit_i             (commit_i),
        .branch_i             (branch_i),
        .src1_o               (src1),
        .src2_o               (src2),
        .old_dst_o            (old_dst),
        .rdy1_o               (rdy1),
        .rdy2_o               (rdy2),
        .checkpoint_o         (ckpt_label),
        .out_of_checkpoints_o (out_of_ckpt)
    );

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            in_progress_q <= 1'b0;
            ack_q         <= 1'b0;
            uop_valid_q   <= 1'b0;
        end else begin
            in_progress_q <= rename_fire;
            uop_valid_q   <= in_progress_q;   // Single-cycle pulse
            if (in_progress_q) begin
                ack_q <= 1'b1;
            end else if (!req_i) begin
                ack_q <= 1'b0;                // Return to zero once req drops
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rename_fire) begin
            pdst_q <= dec.write_rd ? free_preg : '0;   // p0 when nothing is written
        end
        if (in_progress_q) begin
            uop_q <= '{prs1: src1, prs2: src2, pdst: pdst_q, old_pdst: old_dst,
                       rdy1: rdy1, rdy2: rdy2, checkpoint: ckpt_label};
        end
    end

    assign ack_o                = ack_q;
    assign uop_valid_o          = uop_valid_q;
    assign uop_o                = uop_q;
    assign out_of_checkpoints_o = out_of_ckpt;

endmodule

/* rename_table.sv */
// At most NUM_CHECKPOINTS-1 live checkpoints; caller must not checkpoint when out_of_checkpoints_o
`timescale 1ns/1ns

module rename_table
    import rename_isa_pkg::*, rename_core_pkg::*;
(
    input  logic           clk_i,
    input  logic           rstn_i,
    input  decoded_instr_t dec_i,
    input  logic           rename_i,       // Read and write the map this cycle
    input  phreg_t         new_dst_i,      // Register taken from the free list
    input  logic           checkpoint_i,   // Branch takes a new map version
    input  wb_t            wb_i,
    input  commit_t        commit_i,
    input  branch_ctl_t    branch_i,
    output phreg_t         src1_o,
    output phreg_t         src2_o,
    output phreg_t         old_dst_o,
    output logic           rdy1_o,
    output logic           rdy2_o,
    output checkpoint_ptr  checkpoint_o,   // Label to recover to
    output logic           out_of_checkpoints_o
);

    typedef logic [NUM_ISA_REGISTERS-1:0] rdy_vec_t;

    phreg_t        map_q [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    phreg_t        map_d [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    rdy_vec_t      rdy_q [NUM_CHECKPOINTS];
    rdy_vec_t      rdy_d [NUM_CHECKPOINTS];
    phreg_t        commit_map_q [NUM_ISA_REGISTERS];
    phreg_t        commit_map_d [NUM_ISA_REGISTERS];

    checkpoint_ptr head_q, head_d;     // Working version
    checkpoint_ptr tail_q, tail_d;     // Oldest live checkpoint
    checkpoint_ptr count_q, count_d;   // Live checkpoints
    checkpoint_ptr next_ver;

    logic          write_en;
    logic          byp1;
    logic          byp2;
    phreg_t        cur_src1;
    phreg_t        cur_src2;

    assign next_ver = head_q + 1'b1;
    assign write_en = rename_i && dec_i.write_rd;
    assign cur_src1 = map_q[head_q][dec_i.rs1];
    assign cur_src2 = map_q[head_q][dec_i.rs2];

    // Writeback landing in the same cycle as the read
    assign byp1 = wb_i.valid && (wb_i.vreg == dec_i.rs1) && (wb_i.preg == cur_src1);
    assign byp2 = wb_i.valid && (wb_i.vreg == dec_i.rs2) && (wb_i.preg == cur_src2);

    assign out_of_checkpoints_o = (count_q == checkpoint_ptr'(NUM_CHECKPOINTS - 1));

    always_comb begin
        map_d        = map_q;
        rdy_d        = rdy_q;
        commit_map_d = commit_map_q;
        head_d       = head_q;
        tail_d       = tail_q;
        count_d      = count_q;

        if (commit_i.valid) begin
            commit_map_d[commit_i.vreg] = commit_i.new_preg;
        end

        if (branch_i.exception) begin
            // Committed map becomes version 0, all values ready
            map_d[0] = commit_map_d;
            rdy_d[0] = '1;
            head_d   = '0;
            tail_d   = '0;
            count_d  = '0;
        end else begin
            // Ready in every version that still maps vreg to preg
            if (wb_i.valid) begin
                for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                    if (map_q[v][wb_i.vreg] == wb_i.preg) begin
                        rdy_d[v][wb_i.vreg] = 1'b1;
                    end
                end
            end

            tail_d = tail_q + checkpoint_ptr'(branch_i.delete_ckpt);

            if (branch_i.recover) begin
                head_d  = branch_i.recover_ckpt;
                count_d = branch_i.recover_ckpt - tail_d;   // Modulo distance
            end else begin
                count_d = count_q + checkpoint_ptr'(checkpoint_i)
                          - checkpoint_ptr'(branch_i.delete_ckpt);
                // Copy forward first, then the rename lands in both versions
                if (checkpoint_i) begin
                    map_d[next_ver] = map_q[head_q];
                    rdy_d[next_ver] = rdy_d[head_q];
                    head_d          = next_ver;
                end
                if (write_en) begin
                    map_d[head_q][dec_i.rd] = new_dst_i;
                    rdy_d[head_q][dec_i.rd] = 1'b0;
                    if (checkpoint_i) begin
                        map_d[next_ver][dec_i.rd] = new_dst_i;
                        rdy_d[next_ver][dec_i.rd] = 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                    map_q[v][r] <= phreg_t'(r);   // Identity map
                end
                commit_map_q[r] <= phreg_t'(r);
            end
            for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                rdy_q[v] <= '1;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            map_q        <= map_d;
            rdy_q        <= rdy_d;
            commit_map_q <= commit_map_d;
            head_q       <= head_d;
            tail_q       <= tail_d;
            count_q      <= count_d;
        end
    end

    // Registered read of the working version
    always_ff @(posedge clk_i) begin
        if (rename_i) begin
            src1_o       <= cur_src1;
            src2_o       <= cur_src2;
            old_dst_o    <= map_q[head_q][dec_i.rd];
            rdy1_o       <= rdy_q[head_q][dec_i.rs1] | byp1 | ~dec_i.use_rs1;
            rdy2_o       <= rdy_q[head_q][dec_i.rs2] | byp2 | ~dec_i.use_rs2;
            checkpoint_o <= head_q;
        end
    end

endmodule

/* free_list.sv */
// Pop on an empty list is not guarded here; commits must return registers in program order
`timescale 1ns/1ns

module free_list
    import rename_isa_pkg::*, rename_core_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        pop_i,          // Rename takes free_preg_o
    input  commit_t     push_i,         // Commit returns old_preg
    input  logic        checkpoint_i,   // Branch renamed this cycle
    input  branch_ctl_t branch_i,
    output phreg_t      free_preg_o,
    output logic        empty_o
);

    phreg_t        regs_q [FREE_LIST_DEPTH];
    fl_ptr_t       head_q;
    fl_ptr_t       tail_q;
    fl_ptr_t       commit_head_q;            // Head as seen by committed state
    fl_ptr_t       snap_q [NUM_CHECKPOINTS]; // Head just after each branch
    fl_ptr_t       head_pop;
    fl_ptr_t       commit_head_d;
    checkpoint_ptr label_q;                  // Tracks the map version in the table

    assign head_pop      = head_q + fl_ptr_t'(pop_i);
    assign commit_head_d = commit_head_q + fl_ptr_t'(push_i.valid);
    assign free_preg_o   = regs_q[head_q[FL_IDX_W-1:0]];
    assign empty_o       = (head_q == tail_q);

    // Storage and tail start full with p32..p63
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < FREE_LIST_DEPTH; i++) begin
                regs_q[i] <= phreg_t'(NUM_ISA_REGISTERS + i);
            end
            tail_q <= fl_ptr_t'(FREE_LIST_DEPTH);   // Wrap bit set, list full
        end else if (push_i.valid) begin
            regs_q[tail_q[FL_IDX_W-1:0]] <= push_i.old_preg;
            tail_q <= tail_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q        <= '0;
            commit_head_q <= '0;
            label_q       <= '0;
        end else begin
            commit_head_q <= commit_head_d;
            if (branch_i.exception) begin
                // Everything past the last commit is squashed
                head_q  <= commit_head_d;
                label_q <= '0;
            end else if (branch_i.recover) begin
                head_q  <= snap_q[branch_i.recover_ckpt];
                label_q <= branch_i.recover_ckpt;
            end else begin
                head_q <= head_pop;
                if (checkpoint_i) begin
                    label_q <= label_q + 1'b1;
                end
            end
        end
    end

    // Snapshot includes the branch's own pop (jalr writes rd)
    always_ff @(posedge clk_i) begin
        if (checkpoint_i && !branch_i.recover && !branch_i.exception) begin
            snap_q[label_q] <= head_pop;
        end
    end

endmodule

/* instr_decode.sv */
// Unknown opcodes decode as using no registers; JAL takes no checkpoint
`timescale 1ns/1ns

module instr_decode
    import rename_isa_pkg::*, rename_core_pkg::*;
(
    input  instr_t         instr_i,
    output decoded_instr_t dec_o
);

    instr_fields_t f;
    logic          use_rs1;
    logic          use_rs2;
    logic          write_rd;
    logic          is_branch;

    assign f = instr_fields_t'(instr_i);

    // Register use by opcode class
    always_comb begin
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        write_rd  = 1'b0;
        is_branch = 1'b0;
        case (f.opcode)
            OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: begin
                write_rd = 1'b1;
            end
            OPCODE_JALR: begin
                use_rs1   = 1'b1;
                write_rd  = 1'b1;
                is_branch = 1'b1;     // Indirect target may be mispredicted
            end
            OPCODE_BRANCH: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                is_branch = 1'b1;
            end
            OPCODE_LOAD, OPCODE_OP_IMM: begin
                use_rs1  = 1'b1;
                write_rd = 1'b1;
            end
            OPCODE_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPCODE_OP: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                write_rd = 1'b1;
            end
            default: ;
        endcase
    end

    // x0 is never renamed
    assign dec_o = '{rs1: f.rs1, rs2: f.rs2, rd: f.rd, use_rs1: use_rs1, use_rs2: use_rs2,
                     write_rd: write_rd && (f.rd != '0), is_branch: is_branch};

endmodule

/* rename_core_pkg.sv */
// Sized for 64 physical registers and 4 map versions; x0 stays mapped to p0 for good
package rename_core_pkg;
    import rename_isa_pkg::*;

    localparam int NUM_PHYS_REGS   = 64;
    localparam int NUM_CHECKPOINTS = 4;
    localparam int FREE_LIST_DEPTH = NUM_PHYS_REGS - NUM_ISA_REGISTERS;
    localparam int FL_IDX_W        = $clog2(FREE_LIST_DEPTH);

    typedef logic [$clog2(NUM_PHYS_REGS)-1:0]   phreg_t;
    typedef logic [$clog2(NUM_CHECKPOINTS)-1:0] checkpoint_ptr;
    typedef logic [FL_IDX_W:0]                  fl_ptr_t;   // Top bit is the wrap flag

    typedef struct packed {
        reg_t rs1;
        reg_t rs2;
        reg_t rd;
        logic use_rs1;
        logic use_rs2;
        logic write_rd;
        logic is_branch;     // Needs a checkpoint
    } decoded_instr_t;

    typedef struct packed {
        phreg_t        prs1;
        phreg_t        prs2;
        phreg_t        pdst;
        phreg_t        old_pdst;
        logic          rdy1;
        logic          rdy2;
        checkpoint_ptr checkpoint;
    } renamed_uop_t;

    typedef struct packed {
        logic   valid;
        reg_t   vreg;
        phreg_t preg;
    } wb_t;

    typedef struct packed {
        logic   valid;
        reg_t   vreg;
        phreg_t new_preg;
        phreg_t old_preg;    // Goes back to the free list
    } commit_t;

    typedef struct packed {
        logic          recover;
        checkpoint_ptr recover_ckpt;
        logic          delete_ckpt;  // Oldest branch resolved correctly
        logic          exception;
    } branch_ctl_t;

endpackage

/* rename_isa_pkg.sv */
// RV32I base encodings only; compressed instructions are not recognised
package rename_isa_pkg;

    localparam int NUM_ISA_REGISTERS = 32;

    typedef logic [$clog2(NUM_ISA_REGISTERS)-1:0] reg_t;   // Architectural register index
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;

    // Field layout shared by all formats that carry rs1, rs2 and rd
    typedef struct packed {
        logic [6:0] funct7;
        reg_t       rs2;
        reg_t       rs1;
        logic [2:0] funct3;
        reg_t       rd;
        opcode_t    opcode;
    } instr_fields_t;

    localparam opcode_t OPCODE_LUI    = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC  = 7'b0010111;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_OP     = 7'b0110011;

endpackage
